//--- src/vlu_settings.svh
// Sizes shared by the vector logic unit
// The beat count port is VLU_CNT_W bits wide and larger counts are clamped
// to VLU_MAX_BEATS by the beat counter
`ifndef VLU_SETTINGS_SVH
`define VLU_SETTINGS_SVH

// Width of one operand or result beat
`define VLU_DATA_W 32

// Largest number of beats in one instruction
`define VLU_MAX_BEATS 16

// Width of the beat count, wide enough to hold VLU_MAX_BEATS
`define VLU_CNT_W 5

`endif

//--- src/vlu_pkg.sv
// Types of the vector logic unit
// Element widths are 8, 16 or 32 bits inside a 32-bit beat
`include "vlu_settings.svh"

package vlu_pkg;

    // Operation selected at start
    typedef enum logic [2:0] {
        op_and = 3'd0,
        op_or  = 3'd1,
        op_xor = 3'd2,
        op_sll = 3'd3,
        op_srl = 3'd4,
        op_sra = 3'd5
    } logic_op_e;

    // Element width, encoded as in vsew
    typedef enum logic [1:0] {
        sew_8  = 2'd0,
        sew_16 = 2'd1,
        sew_32 = 2'd2
    } sew_e;

    // One data beat seen as bytes, halfwords or a single word
    typedef union packed {
        logic [`VLU_DATA_W/8-1:0][7:0]   b;
        logic [`VLU_DATA_W/16-1:0][15:0] h;
        logic [`VLU_DATA_W-1:0]          w;
    } vlu_word_u;

endpackage

//--- src/vlu_seq_fsm.sv
// Sequencer of one vector instruction
// A start during a run is ignored and is honored again in the done cycle
// The reduction flag is dropped for shift operations

module vlu_seq_fsm (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  vlu_pkg::logic_op_e  op,
    input  vlu_pkg::sew_e       sew,
    input  logic                is_reduct,
    input  logic                in_valid,
    input  logic                last_beat,
    output logic                busy,
    output logic                accept,
    output logic                first_beat,
    output vlu_pkg::logic_op_e  cur_op,
    output vlu_pkg::sew_e       cur_sew,
    output logic                cur_reduct,
    output logic                done
);

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_run    = 2'd1,
        st_finish = 2'd2
    } state_e;

    state_e state_q;
    state_e state_next;
    logic   start_ok;
    logic   op_is_shift;
    logic   seen_q;

    assign busy     = (state_q == st_run);
    assign done     = (state_q == st_finish);
    assign start_ok = start & ~busy;
    assign accept   = in_valid & busy;

    assign op_is_shift = (op == vlu_pkg::op_sll) || (op == vlu_pkg::op_srl) ||
                         (op == vlu_pkg::op_sra);

    // No beat taken yet in this run
    assign first_beat = ~seen_q;

    always_comb begin
        state_next = state_q;
        case (state_q)
            st_idle:   if (start) state_next = st_run;
            st_run:    if (accept && last_beat) state_next = st_finish;
            st_finish: state_next = start ? st_run : st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= st_idle;
            seen_q     <= 1'b0;
            cur_op     <= vlu_pkg::op_and;
            cur_sew    <= vlu_pkg::sew_8;
            cur_reduct <= 1'b0;
        end else begin
            state_q <= state_next;
            if (start_ok) begin
                seen_q     <= 1'b0;
                cur_op     <= op;
                cur_sew    <= sew;
                cur_reduct <= is_reduct & ~op_is_shift;
            end else if (accept) begin
                seen_q <= 1'b1;
            end
        end
    end

endmodule

//--- src/vlu_beat_counter.sv
// Counts accepted beats of the current run
// A count of 0 runs one beat and counts above VLU_MAX_BEATS are clamped
`include "vlu_settings.svh"

module vlu_beat_counter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [`VLU_CNT_W-1:0] n_beats,
    input  logic                  accept,
    output logic                  last_beat
);

    localparam logic [`VLU_CNT_W-1:0] max_beats = `VLU_MAX_BEATS;

    logic [`VLU_CNT_W-1:0] target_q;
    logic [`VLU_CNT_W-1:0] count_q;
    logic [`VLU_CNT_W-1:0] target_load;
    logic                  armed_q;

    always_comb begin
        if (n_beats == '0)
            target_load = `VLU_CNT_W'(1);
        else if (n_beats > max_beats)
            target_load = max_beats;
        else
            target_load = n_beats;
    end

    // Armed from an honored start until the last beat is taken
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            target_q <= `VLU_CNT_W'(1);
            count_q  <= '0;
            armed_q  <= 1'b0;
        end else if (start && !armed_q) begin
            target_q <= target_load;
            count_q  <= '0;
            armed_q  <= 1'b1;
        end else if (accept) begin
            count_q <= count_q + 1'b1;
            if (last_beat)
                armed_q <= 1'b0;
        end
    end

    assign last_beat = (count_q == target_q - 1'b1);

endmodule

//--- src/vlu_bitwise.sv
// Bitwise and, or and xor on one beat
// In reduction mode the elements of srca fold into element 0, upper bits zero
// Shift operations give zero here

module vlu_bitwise (
    input  vlu_pkg::logic_op_e op,
    input  vlu_pkg::sew_e      sew,
    input  logic               is_reduct,
    input  vlu_pkg::vlu_word_u srca,
    input  vlu_pkg::vlu_word_u srcb,
    output vlu_pkg::vlu_word_u result
);

    function automatic logic [31:0] apply_op(input vlu_pkg::logic_op_e f_op,
                                             input logic [31:0] x,
                                             input logic [31:0] y);
        case (f_op)
            vlu_pkg::op_and: return x & y;
            vlu_pkg::op_or:  return x | y;
            vlu_pkg::op_xor: return x ^ y;
            default:         return '0;
        endcase
    endfunction

    logic [31:0] fold;

    // Zero-extended elements keep the upper bits clear for all three ops
    always_comb begin
        case (sew)
            vlu_pkg::sew_8: begin
                fold = apply_op(op, {24'b0, srca.b[0]}, {24'b0, srca.b[1]});
                fold = apply_op(op, fold, {24'b0, srca.b[2]});
                fold = apply_op(op, fold, {24'b0, srca.b[3]});
            end
            vlu_pkg::sew_16: begin
                fold = apply_op(op, {16'b0, srca.h[0]}, {16'b0, srca.h[1]});
            end
            default: begin
                // One word element folds to itself
                fold = (op inside {vlu_pkg::op_and, vlu_pkg::op_or, vlu_pkg::op_xor}) ?
                       srca.w : '0;
            end
        endcase
    end

    always_comb begin
        if (is_reduct)
            result.w = fold;
        else
            result.w = apply_op(op, srca.w, srcb.w);
    end

endmodule

//--- src/vlu_shifter.sv
// Per-element shifter for 8, 16 and 32-bit elements
// Shift amount is the low log2(SEW) bits of the matching srcb element
// Non-shift operations give zero

module vlu_shifter (
    input  vlu_pkg::logic_op_e op,
    input  vlu_pkg::sew_e      sew,
    input  vlu_pkg::vlu_word_u srca,
    input  vlu_pkg::vlu_word_u srcb,
    output vlu_pkg::vlu_word_u result
);

    always_comb begin
        result = '0;
        case (sew)
            vlu_pkg::sew_8: begin
                for (int i = 0; i < 4; i++) begin
                    case (op)
                        vlu_pkg::op_sll: result.b[i] = srca.b[i] << srcb.b[i][2:0];
                        vlu_pkg::op_srl: result.b[i] = srca.b[i] >> srcb.b[i][2:0];
                        vlu_pkg::op_sra:
                            result.b[i] = $signed(srca.b[i]) >>> srcb.b[i][2:0];
                        default: result.b[i] = '0;
                    endcase
                end
            end
            vlu_pkg::sew_16: begin
                for (int i = 0; i < 2; i++) begin
                    case (op)
                        vlu_pkg::op_sll: result.h[i] = srca.h[i] << srcb.h[i][3:0];
                        vlu_pkg::op_srl: result.h[i] = srca.h[i] >> srcb.h[i][3:0];
                        vlu_pkg::op_sra:
                            result.h[i] = $signed(srca.h[i]) >>> srcb.h[i][3:0];
                        default: result.h[i] = '0;
                    endcase
                end
            end
            vlu_pkg::sew_32: begin
                case (op)
                    vlu_pkg::op_sll: result.w = srca.w << srcb.w[4:0];
                    vlu_pkg::op_srl: result.w = srca.w >> srcb.w[4:0];
                    vlu_pkg::op_sra: result.w = $signed(srca.w) >>> srcb.w[4:0];
                    default:         result.w = '0;
                endcase
            end
            // Reserved width leaves the result at zero
            default: result = '0;
        endcase
    end

endmodule

//--- src/vlu_logic_alu.sv
// Logic ALU of the vector unit
// Only one of the bitwise and shift paths is nonzero for a given op

module vlu_logic_alu (
    input  vlu_pkg::logic_op_e op,
    input  vlu_pkg::sew_e      sew,
    input  logic               is_reduct,
    input  vlu_pkg::vlu_word_u srca,
    input  vlu_pkg::vlu_word_u srcb,
    output vlu_pkg::vlu_word_u result
);

    vlu_pkg::vlu_word_u bitwise_result;
    vlu_pkg::vlu_word_u shifter_result;

    vlu_bitwise bitwise0 (
        .op        (op),
        .sew       (sew),
        .is_reduct (is_reduct),
        .srca      (srca),
        .srcb      (srcb),
        .result    (bitwise_result)
    );

    vlu_shifter shifter0 (
        .op     (op),
        .sew    (sew),
        .srca   (srca),
        .srcb   (srcb),
        .result (shifter_result)
    );

    // Final merge
    assign result.w = bitwise_result.w | shifter_result.w;

endmodule

//--- src/vlu_result_stage.sv
// Result register and reduction accumulator
// Element-wise results show one cycle after their beat with out_valid
// The reduction total lands in out_data one cycle after the last beat

module vlu_result_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               accept,
    input  logic               first_beat,
    input  logic               last_beat,
    input  vlu_pkg::logic_op_e cur_op,
    input  vlu_pkg::sew_e      cur_sew,
    input  logic               cur_reduct,
    input  vlu_pkg::vlu_word_u alu_result,
    input  vlu_pkg::vlu_word_u srcb,
    output logic               out_valid,
    output vlu_pkg::vlu_word_u out_data
);

    logic [31:0] seed;
    logic [31:0] acc_base;
    logic [31:0] acc_q;
    logic [31:0] acc_next;

    // Element 0 of srcb starts the fold
    always_comb begin
        case (cur_sew)
            vlu_pkg::sew_8:  seed = {24'b0, srcb.b[0]};
            vlu_pkg::sew_16: seed = {16'b0, srcb.h[0]};
            default:         seed = srcb.w;
        endcase
    end

    assign acc_base = first_beat ? seed : acc_q;

    always_comb begin
        case (cur_op)
            vlu_pkg::op_and: acc_next = acc_base & alu_result.w;
            vlu_pkg::op_or:  acc_next = acc_base | alu_result.w;
            vlu_pkg::op_xor: acc_next = acc_base ^ alu_result.w;
            default:         acc_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept && cur_reduct)
            acc_q <= acc_next;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= accept & ~cur_reduct;
            if (accept) begin
                if (!cur_reduct)
                    out_data <= alu_result;
                else if (last_beat)
                    out_data.w <= acc_next;
            end
        end
    end

endmodule

//--- src/vlu_top.sv
// Vector logic unit for and, or, xor and shifts
// No handshake on inputs or outputs, results are pulses to be taken
// Masking, tail policies and widening forms are not supported
`include "vlu_settings.svh"

module vlu_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  vlu_pkg::logic_op_e    op,
    input  vlu_pkg::sew_e         sew,
    input  logic                  is_reduct,
    input  logic [`VLU_CNT_W-1:0] n_beats,
    input  logic                  in_valid,
    input  vlu_pkg::vlu_word_u    in_a,
    input  vlu_pkg::vlu_word_u    in_b,
    output logic                  busy,
    output logic                  out_valid,
    output vlu_pkg::vlu_word_u    out_data,
    output logic                  done
);

    logic               accept;
    logic               first_beat;
    logic               last_beat;
    vlu_pkg::logic_op_e cur_op;
    vlu_pkg::sew_e      cur_sew;
    logic               cur_reduct;
    vlu_pkg::vlu_word_u alu_result;

    vlu_seq_fsm seq0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .op         (op),
        .sew        (sew),
        .is_reduct  (is_reduct),
        .in_valid   (in_valid),
        .last_beat  (last_beat),
        .busy       (busy),
        .accept     (accept),
        .first_beat (first_beat),
        .cur_op     (cur_op),
        .cur_sew    (cur_sew),
        .cur_reduct (cur_reduct),
        .done       (done)
    );

    vlu_beat_counter cnt0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .n_beats   (n_beats),
        .accept    (accept),
        .last_beat (last_beat)
    );

    // Datapath runs on the latched controls and the raw beat
    vlu_logic_alu alu0 (
        .op        (cur_op),
        .sew       (cur_sew),
        .is_reduct (cur_reduct),
        .srca      (in_a),
        .srcb      (in_b),
        .result    (alu_result)
    );

    vlu_result_stage res0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .accept     (accept),
        .first_beat (first_beat),
        .last_beat  (last_beat),
        .cur_op     (cur_op),
        .cur_sew    (cur_sew),
        .cur_reduct (cur_reduct),
        .alu_result (alu_result),
        .srcb       (in_b),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

//--- test/vlu_assertions.sv
// Protocol checks bound into vlu_top
// fail_count holds the number of failed assertions

module vlu_assertions (
    input logic clk,
    input logic arst_n,
    input logic start,
    input logic busy,
    input logic out_valid,
    input logic done
);

    int unsigned fail_count = 0;

    // Results only follow a busy cycle
    result_after_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid || done) |-> $past(busy))
        else begin
            fail_count++;
            $error("out_valid or done without busy in the previous cycle");
        end

    done_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done held high for more than one cycle");
        end

    busy_needs_start: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(busy) |-> $past(start))
        else begin
            fail_count++;
            $error("busy rose without a start");
        end

endmodule

bind vlu_top vlu_assertions chk0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .busy      (busy),
    .out_valid (out_valid),
    .done      (done)
);

//--- test/vlu_tb.sv
// Directed testbench for vlu_top with a per-element model of the logic rules
// Operands are random from a fixed seed
// Bound protocol assertions are counted and checked at the end of the run
`include "vlu_settings.svh"

module vlu_tb;

    // Tests take about 200 cycles
    localparam int max_cycles = 2000;

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    logic start = 1'b0;
    logic is_reduct = 1'b0;
    logic in_valid = 1'b0;
    logic [`VLU_CNT_W-1:0] n_beats = '0;
    vlu_pkg::logic_op_e op = vlu_pkg::op_and;
    vlu_pkg::sew_e sew = vlu_pkg::sew_8;
    vlu_pkg::vlu_word_u in_a = '0;
    vlu_pkg::vlu_word_u in_b = '0;
    logic busy;
    logic out_valid;
    logic done;
    vlu_pkg::vlu_word_u out_data;
    string test_name = "reset";
    int cycle_count = 0;

    vlu_top dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_bit(input string what, input logic want, input logic got);
        if (got !== want) begin
            $display("ERR %s %s expected %b actual %b", test_name, what, want, got);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string what, input vlu_pkg::vlu_word_u want,
                              input vlu_pkg::vlu_word_u got);
        if (got.w !== want.w) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, want.w, got.w);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    function automatic int sew_bits(input vlu_pkg::sew_e s);
        return (s == vlu_pkg::sew_8) ? 8 : (s == vlu_pkg::sew_16) ? 16 : 32;
    endfunction

    // One w-bit element, operands zero-extended to 32 bits
    function automatic logic [31:0] elem_op(input vlu_pkg::logic_op_e f_op, input int w,
                                            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] mask;
        int amt;
        mask = (w == 32) ? '1 : (32'd1 << w) - 1;
        amt = y % w;
        case (f_op)
            vlu_pkg::op_and: return x & y;
            vlu_pkg::op_or:  return x | y;
            vlu_pkg::op_xor: return x ^ y;
            vlu_pkg::op_sll: return (x << amt) & mask;
            vlu_pkg::op_srl: return x >> amt;
            default:         return (x >> amt) | (x[w-1] ? (mask & ~(mask >> amt)) : 32'd0);
        endcase
    endfunction

    // Element-wise beat result, or acc folded with every element of a
    function automatic vlu_pkg::vlu_word_u model(input vlu_pkg::logic_op_e f_op,
            input vlu_pkg::sew_e f_sew, input logic red, input logic first,
            input vlu_pkg::vlu_word_u acc, input vlu_pkg::vlu_word_u a,
            input vlu_pkg::vlu_word_u b);
        vlu_pkg::vlu_word_u r;
        logic [31:0] mask;
        int w;
        w = sew_bits(f_sew);
        mask = (w == 32) ? '1 : (32'd1 << w) - 1;
        r.w = !red ? 32'd0 : first ? (b.w & mask) : acc.w;
        for (int i = 0; i < 32 / w; i++) begin
            if (red)
                r.w = elem_op(f_op, w, r.w, (a.w >> (i * w)) & mask);
            else
                r.w |= elem_op(f_op, w, (a.w >> (i * w)) & mask,
                               (b.w >> (i * w)) & mask) << (i * w);
        end
        return r;
    endfunction

    // Issue one instruction and check every cycle up to done
    task automatic run_instr(input string name, input vlu_pkg::logic_op_e f_op,
                             input vlu_pkg::sew_e f_sew, input logic red, input int n,
                             input int gap, input logic stray);
        vlu_pkg::vlu_word_u want;
        logic red_eff;
        int beats;
        test_name = name;
        red_eff = red && (f_op inside {vlu_pkg::op_and, vlu_pkg::op_or, vlu_pkg::op_xor});
        beats = (n == 0) ? 1 : n;
        start = 1'b1;
        op = f_op;
        sew = f_sew;
        is_reduct = red;
        n_beats = `VLU_CNT_W'(n);
        tick();
        start = 1'b0;
        check_bit("busy after start", 1'b1, busy);
        for (int i = 0; i < beats; i++) begin
            in_valid = 1'b1;
            in_a.w = $urandom;
            in_b.w = $urandom;
            // Second start mid-run must not change op or length
            if (stray && i == 0) begin
                start = 1'b1;
                op = vlu_pkg::op_sra;
                n_beats = `VLU_CNT_W'(9);
            end
            want = model(f_op, f_sew, red_eff, i == 0, want, in_a, in_b);
            tick();
            in_valid = 1'b0;
            start = 1'b0;
            check_bit("out_valid", !red_eff, out_valid);
            check_bit("done", i == beats - 1, done);
            check_bit("busy", i != beats - 1, busy);
            if (!red_eff || i == beats - 1)
                check_word("out_data", want, out_data);
            repeat (gap) begin
                tick();
                check_bit("out_valid in gap", 1'b0, out_valid);
                check_bit("done in gap", 1'b0, done);
            end
        end
    endtask

    initial begin
        vlu_pkg::logic_op_e logic_ops[3];
        vlu_pkg::logic_op_e shift_ops[3];
        vlu_pkg::sew_e sews[3];
        void'($urandom(32'hf23c_8666));
        logic_ops = '{vlu_pkg::op_and, vlu_pkg::op_or, vlu_pkg::op_xor};
        shift_ops = '{vlu_pkg::op_sll, vlu_pkg::op_srl, vlu_pkg::op_sra};
        sews = '{vlu_pkg::sew_8, vlu_pkg::sew_16, vlu_pkg::sew_32};
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_bit("busy", 1'b0, busy);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("done", 1'b0, done);
        check_word("out_data", '0, out_data);
        foreach (sews[s]) begin
            foreach (logic_ops[k])
                run_instr("elementwise", logic_ops[k], sews[s], 1'b0, 4, 0, 1'b0);
            foreach (shift_ops[k])
                run_instr("shift", shift_ops[k], sews[s], 1'b0, 5, 0, 1'b0);
        end
        run_instr("and reduction", vlu_pkg::op_and, vlu_pkg::sew_8, 1'b1, 3, 2, 1'b0);
        run_instr("or reduction", vlu_pkg::op_or, vlu_pkg::sew_16, 1'b1, 4, 1, 1'b0);
        run_instr("xor reduction", vlu_pkg::op_xor, vlu_pkg::sew_8, 1'b1, 5, 3, 1'b0);
        run_instr("word reduction", vlu_pkg::op_or, vlu_pkg::sew_32, 1'b1, 3, 1, 1'b0);
        run_instr("word xor reduction", vlu_pkg::op_xor, vlu_pkg::sew_32, 1'b1, 3, 1, 1'b0);
        run_instr("zero beats", vlu_pkg::op_xor, vlu_pkg::sew_16, 1'b0, 0, 0, 1'b0);
        run_instr("start while busy", vlu_pkg::op_xor, vlu_pkg::sew_32, 1'b0, 2, 0, 1'b1);
        test_name = "valid while idle";
        in_valid = 1'b1;
        tick();
        in_valid = 1'b0;
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("busy", 1'b0, busy);
        run_instr("reduct flag on shift", vlu_pkg::op_sra, vlu_pkg::sew_16, 1'b1, 3, 0, 1'b0);
        if (dut0.chk0.fail_count != 0) begin
            $display("Protocol assertion failed %0d times", dut0.chk0.fail_count);
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+src
src/vlu_pkg.sv
src/vlu_seq_fsm.sv
src/vlu_beat_counter.sv
src/vlu_bitwise.sv
src/vlu_shifter.sv
src/vlu_logic_alu.sv
src/vlu_result_stage.sv
src/vlu_top.sv
test/vlu_assertions.sv
test/vlu_tb.sv
